// ==== design/rdma_req_arb_macros.svh ====
`ifndef RDMA_REQ_ARB_MACROS_SVH
`define RDMA_REQ_ARB_MACROS_SVH

// ****************************************
// channel count and index width.
// ****************************************
`define RDMA_ARB_CHNL_NUM 4 // number of request channels sharing the stream.
`define RDMA_ARB_CHNL_LOG 2 // bits needed to name one channel.

// ****************************************
// stream beat field widths.
// ****************************************
`define RDMA_ARB_DATA_W 64 // payload bits per beat.
`define RDMA_ARB_USER_W 128 // request descriptor bits carried with each beat.
`define RDMA_ARB_KEEP_W (`RDMA_ARB_DATA_W / 32) // one keep bit covers one 32-bit word.

// the index width must cover every channel number.
// a channel count of 2 or more is expected.

`endif

// ==== design/rdma_req_arb_pkg.sv ====
`include "rdma_req_arb_macros.svh"

package rdma_req_arb_pkg;

    // ****************************************
    // channel index.
    // ****************************************
    typedef logic [`RDMA_ARB_CHNL_LOG-1:0] chnl_idx_t; // names one request channel.

    // ****************************************
    // one stream beat without its valid.
    // ****************************************
    typedef struct packed {
        logic                        last; // set on the final beat of a packet.
        logic [`RDMA_ARB_DATA_W-1:0] data; // request payload word.
        logic [`RDMA_ARB_USER_W-1:0] user; // request or interrupt descriptor.
        logic [`RDMA_ARB_KEEP_W-1:0] keep; // enables for each 32-bit word.
    } req_beat_t;

    // ****************************************
    // arbiter FSM states, one hot.
    // ****************************************
    typedef enum logic [2:0] {
        IDLE      = 3'b001, // no channel is requesting.
        SCHEDULE  = 3'b010, // the grant follows the round-robin candidate.
        REQ_TRANS = 3'b100  // the grant is locked until the packet ends.
    } arb_state_e;

endpackage : rdma_req_arb_pkg

// ==== design/rr_grant_picker.sv ====
`timescale 1ns/1ps
`include "rdma_req_arb_macros.svh"

module rr_grant_picker (
    input  logic                              rdma_clk,
    input  logic                              rst_n,
    input  logic [`RDMA_ARB_CHNL_NUM-1:0]     s_req_valid,  // request valid of every channel.
    input  logic                              pkt_done,     // last beat accepted this cycle.
    input  rdma_req_arb_pkg::chnl_idx_t       grant_idx,    // channel currently granted.
    output rdma_req_arb_pkg::chnl_idx_t       rr_candidate  // next channel in round-robin order.
);

    import rdma_req_arb_pkg::*;

    chnl_idx_t                       last_chnl;   // channel whose packet finished last.
    logic [2*`RDMA_ARB_CHNL_NUM-1:0] valid_twice; // valid vector laid end to end twice.
    logic [`RDMA_ARB_CHNL_NUM-1:0]   valid_rot;   // bit k is channel last plus one plus k.

    // folds a position back into the channel range.
    function automatic chnl_idx_t wrap_idx(input int unsigned pos);
        return chnl_idx_t'(pos % `RDMA_ARB_CHNL_NUM);
    endfunction

    // ****************************************
    // last served channel.
    // ****************************************
    always_ff @(posedge rdma_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_chnl <= '0; // the search starts after channel 0.
        end else if (pkt_done) begin
            last_chnl <= grant_idx; // the channel that just sent its last beat.
        end
    end

    // ****************************************
    // rotating search.
    // ****************************************
    assign valid_twice = {s_req_valid, s_req_valid}; // doubling makes the rotation a slice.
    assign valid_rot   = valid_twice[last_chnl + 1 +: `RDMA_ARB_CHNL_NUM]; // starts after last.

    always_comb begin
        rr_candidate = wrap_idx(last_chnl + 1); // no request leaves the next channel in line.
        for (int k = `RDMA_ARB_CHNL_NUM - 1; k >= 0; k--) begin
            if (valid_rot[k]) begin
                rr_candidate = wrap_idx(last_chnl + 1 + k); // the lowest offset wins.
            end
        end
    end

endmodule

// ==== design/req_arb_fsm.sv ====
`timescale 1ns/1ps
`include "rdma_req_arb_macros.svh"

module req_arb_fsm (
    input  logic                          rdma_clk,
    input  logic                          rst_n,
    input  logic [`RDMA_ARB_CHNL_NUM-1:0] s_req_valid,  // request valid of every channel.
    input  rdma_req_arb_pkg::chnl_idx_t   rr_candidate, // channel offered by the picker.
    input  logic                          m_req_valid,  // output beat is valid.
    input  logic                          m_req_last,   // output beat ends a packet.
    input  logic                          m_req_ready,  // sink accepts the output beat.
    output rdma_req_arb_pkg::chnl_idx_t   grant_idx,    // channel routed to the output.
    output logic                          grant_active, // the mux may forward a beat.
    output logic                          pkt_done      // last beat of a packet accepted.
);

    import rdma_req_arb_pkg::*;

    arb_state_e cur_state;    // present state.
    arb_state_e nxt_state;    // state after the next edge.
    chnl_idx_t  grant_lock;   // grant held for the rest of a packet.
    logic       any_valid;    // at least one channel requests.
    logic       is_schedule;  // FSM sits in SCHEDULE.
    logic       is_req_trans; // FSM sits in REQ_TRANS.
    logic       lock_grant;   // the packet continues past this cycle.

    assign any_valid    = |s_req_valid;
    assign is_schedule  = (cur_state == SCHEDULE);
    assign is_req_trans = (cur_state == REQ_TRANS);
    assign pkt_done     = m_req_valid & m_req_ready & m_req_last; // last beat handshake.
    assign lock_grant   = is_schedule & ~pkt_done & any_valid; // entry to REQ_TRANS.

    // ****************************************
    // grant outputs.
    // ****************************************
    assign grant_active = is_schedule | is_req_trans;
    assign grant_idx    = is_schedule ? rr_candidate : grant_lock; // locked once a packet runs.

    always_ff @(posedge rdma_clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_lock <= '0;
        end else if (lock_grant) begin
            grant_lock <= rr_candidate; // freeze the channel picked in SCHEDULE.
        end
    end

    // ****************************************
    // state register and transitions.
    // ****************************************
    always_ff @(posedge rdma_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_state <= IDLE;
        end else begin
            cur_state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = cur_state; // hold unless a rule below fires.
        case (cur_state)
            IDLE: begin
                if (any_valid) begin
                    nxt_state = SCHEDULE; // a request wakes the arbiter.
                end
            end
            SCHEDULE: begin
                if (pkt_done) begin
                    nxt_state = SCHEDULE; // a one beat packet finished here.
                end else if (any_valid) begin
                    nxt_state = REQ_TRANS; // lock the grant for a longer packet.
                end else begin
                    nxt_state = IDLE; // nothing left to serve.
                end
            end
            REQ_TRANS: begin
                if (pkt_done) begin
                    nxt_state = SCHEDULE; // pick the next channel without a gap.
                end
            end
            default: nxt_state = IDLE; // recover from an illegal encoding.
        endcase
    end

endmodule

// ==== design/req_stream_mux.sv ====
`timescale 1ns/1ps
`include "rdma_req_arb_macros.svh"

module req_stream_mux (
    input  logic [`RDMA_ARB_CHNL_NUM-1:0]                         s_req_valid,  // channel valids.
    input  rdma_req_arb_pkg::req_beat_t [`RDMA_ARB_CHNL_NUM-1:0]  s_req_beat,   // channel beats.
    input  rdma_req_arb_pkg::chnl_idx_t                           grant_idx,    // routed channel.
    input  logic                                                  grant_active, // route enable.
    input  logic                                                  m_req_ready,  // sink ready.
    output logic [`RDMA_ARB_CHNL_NUM-1:0]                         s_req_ready,  // channel readies.
    output logic                                                  m_req_valid,  // output valid.
    output rdma_req_arb_pkg::req_beat_t                           m_req_beat    // output beat.
);

    // ****************************************
    // forward path.
    // ****************************************
    // the granted channel drives the output only while a grant is active.
    // tuser is carried as an opaque field and is never looked at here.
    assign m_req_valid = grant_active & s_req_valid[grant_idx];
    assign m_req_beat  = grant_active ? s_req_beat[grant_idx] : '0; // idle output is all zero.

    // ****************************************
    // ready return path.
    // ****************************************
    always_comb begin
        s_req_ready = '0; // channels without the grant always see ready low.
        if (grant_active) begin
            s_req_ready[grant_idx] = m_req_ready; // back-pressure reaches the owner only.
        end
    end

    // a beat held by a stalled sink stays on the output because the grant
    // cannot move until the packet ends and the owner keeps its beat.

endmodule

// ==== design/rdma_req_arbiter.sv ====
`timescale 1ns/1ps
`include "rdma_req_arb_macros.svh"

module rdma_req_arbiter (
    input  logic                                                  rdma_clk,
    input  logic                                                  rst_n,

    // request channels.
    input  logic [`RDMA_ARB_CHNL_NUM-1:0]                         s_req_valid,
    input  rdma_req_arb_pkg::req_beat_t [`RDMA_ARB_CHNL_NUM-1:0]  s_req_beat,
    output logic [`RDMA_ARB_CHNL_NUM-1:0]                         s_req_ready,

    // shared outgoing request stream.
    output logic                                                  m_req_valid,
    output rdma_req_arb_pkg::req_beat_t                           m_req_beat,
    input  logic                                                  m_req_ready
);

    import rdma_req_arb_pkg::*;

    chnl_idx_t rr_candidate; // next channel in round-robin order.
    chnl_idx_t grant_idx;    // channel currently routed to the output.
    logic      grant_active; // high in SCHEDULE and REQ_TRANS.
    logic      pkt_done;     // last beat of a packet accepted.

    // ****************************************
    // round-robin candidate.
    // ****************************************
    rr_grant_picker u_picker (
        .rdma_clk     (rdma_clk),
        .rst_n        (rst_n),
        .s_req_valid  (s_req_valid),
        .pkt_done     (pkt_done),
        .grant_idx    (grant_idx),
        .rr_candidate (rr_candidate)
    );

    // ****************************************
    // grant control.
    // ****************************************
    req_arb_fsm u_fsm (
        .rdma_clk     (rdma_clk),
        .rst_n        (rst_n),
        .s_req_valid  (s_req_valid),
        .rr_candidate (rr_candidate),
        .m_req_valid  (m_req_valid),
        .m_req_last   (m_req_beat.last), // packet end seen on the output.
        .m_req_ready  (m_req_ready),
        .grant_idx    (grant_idx),
        .grant_active (grant_active),
        .pkt_done     (pkt_done)
    );

    // ****************************************
    // data path.
    // ****************************************
    req_stream_mux u_mux (
        .s_req_valid  (s_req_valid),
        .s_req_beat   (s_req_beat),
        .grant_idx    (grant_idx),
        .grant_active (grant_active),
        .m_req_ready  (m_req_ready),
        .s_req_ready  (s_req_ready),
        .m_req_valid  (m_req_valid),
        .m_req_beat   (m_req_beat)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic rdma_clk,
    output logic rst_n
);

    // ****************************************
    // 100 MHz clock and power-on reset.
    // ****************************************
    initial begin
        rdma_clk = 1'b0;
        forever #5 rdma_clk = ~rdma_clk; // 10 ns period.
    end

    initial begin
        rst_n = 1'b0; // reset is held from time zero.
        repeat (8) @(posedge rdma_clk);
        #1 rst_n = 1'b1; // released just after the eighth edge.
    end

endmodule

// ==== sim/rdma_req_arb_checker.sv ====
`timescale 1ns/1ps
`include "rdma_req_arb_macros.svh"

module rdma_req_arb_checker (
    input logic                                                 rdma_clk,
    input logic                                                 rst_n,
    input logic [`RDMA_ARB_CHNL_NUM-1:0]                        s_req_valid,
    input logic [`RDMA_ARB_CHNL_NUM-1:0]                        s_req_ready,
    input logic                                                 m_req_valid,
    input rdma_req_arb_pkg::req_beat_t                          m_req_beat,
    input logic                                                 m_req_ready,
    input rdma_req_arb_pkg::chnl_idx_t                          grant_idx
);

    int assert_fails = 0; // number of assertion failures seen so far.

    // ****************************************
    // grant rules.
    // ****************************************
    a_ready_owner : assert property (@(posedge rdma_clk) disable iff (!rst_n)
        (m_req_valid && !(m_req_ready && m_req_beat.last))
            |=> (s_req_ready == (`RDMA_ARB_CHNL_NUM'(m_req_ready) << $past(grant_idx))))
        else begin
            $error("ready reached a channel that does not own the running packet.");
            assert_fails++;
        end

    a_valid_owner : assert property (@(posedge rdma_clk) disable iff (!rst_n)
        (m_req_valid && !m_req_ready) |=> (m_req_valid && s_req_valid[$past(grant_idx)]))
        else begin
            $error("a stalled beat lost its valid or its owner.");
            assert_fails++;
        end

    // ****************************************
    // stream rules.
    // ****************************************
    a_beat_hold : assert property (@(posedge rdma_clk) disable iff (!rst_n)
        (m_req_valid && !m_req_ready) |=> $stable(m_req_beat)) // stalled beat holds.
        else begin
            $error("output beat changed while stalled.");
            assert_fails++;
        end

endmodule

bind rdma_req_arbiter rdma_req_arb_checker u_checker (
    .rdma_clk    (rdma_clk),
    .rst_n       (rst_n),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .m_req_valid (m_req_valid),
    .m_req_beat  (m_req_beat),
    .m_req_ready (m_req_ready),
    .grant_idx   (grant_idx)
);

// ==== sim/tb_rdma_req_arbiter.sv ====
`timescale 1ns/1ps
`include "rdma_req_arb_macros.svh"

module tb_rdma_req_arbiter;

    import rdma_req_arb_pkg::*;

    localparam int NCH      = `RDMA_ARB_CHNL_NUM; // channel count.
    localparam int N_ROWS   = 6;                  // rows of the stimulus table.
    localparam int LATE_CYC = 3;                  // start cycle of a late channel.

    logic                  rdma_clk;
    logic                  rst_n;
    logic [NCH-1:0]        s_req_valid;
    req_beat_t [NCH-1:0]   s_req_beat;
    logic [NCH-1:0]        s_req_ready;
    logic                  m_req_valid;
    req_beat_t             m_req_beat;
    logic                  m_req_ready;

    // ****************************************
    // stimulus table.
    // ****************************************
    logic [NCH-1:0] row_mask  [N_ROWS];      // channels that send one packet.
    logic [NCH-1:0] row_late  [N_ROWS];      // channels that start a few cycles late.
    int             row_len   [N_ROWS][NCH]; // packet length of each channel.
    logic [7:0]     row_stall [N_ROWS];      // ready pattern, one bit per cycle.
    bit             row_rand  [N_ROWS];      // random ready instead of the pattern.
    int             row_order [N_ROWS][NCH]; // expected grant order.
    int             row_ord_n [N_ROWS];      // number of grants in the row.

    req_beat_t      chq [NCH][$];            // beats still to be sent by each channel.
    req_beat_t      exp_q [$];               // beats expected on the output, in order.
    req_beat_t      exp_b;
    logic [NCH-1:0] acc_flag;                // beats accepted at the last edge.
    logic [NCH-1:0] cur_late;
    logic [7:0]     cur_stall;
    bit             cur_rand;
    bit             driving;
    int             row_cyc;
    int             errs;
    int             total_beats;
    bit             table_ready;

    tb_clk_gen u_clk (.rdma_clk(rdma_clk), .rst_n(rst_n));

    rdma_req_arbiter uut (
        .rdma_clk    (rdma_clk),
        .rst_n       (rst_n),
        .s_req_valid (s_req_valid),
        .s_req_beat  (s_req_beat),
        .s_req_ready (s_req_ready),
        .m_req_valid (m_req_valid),
        .m_req_beat  (m_req_beat),
        .m_req_ready (m_req_ready)
    );

    task automatic set_row(input int r, input logic [NCH-1:0] mask, input logic [NCH-1:0] late,
                           input int l0, input int l1, input int l2, input int l3,
                           input logic [7:0] stall, input bit rnd);
        row_mask[r]  = mask;
        row_late[r]  = late;
        row_stall[r] = stall;
        row_rand[r]  = rnd;
        row_len[r][0] = l0;
        row_len[r][1] = l1;
        row_len[r][2] = l2;
        row_len[r][3] = l3;
    endtask

    // the next grant in the model is the first requester after the last one served.
    task automatic build_orders();
        int ref_last;
        int ch;
        ref_last    = 0; // reset leaves channel 0 as the last one served.
        total_beats = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            row_ord_n[r] = 0;
            for (int k = 1; k <= NCH; k++) begin
                ch = (ref_last + k) % NCH;
                if (row_mask[r][ch]) begin
                    row_order[r][row_ord_n[r]] = ch;
                    row_ord_n[r]++;
                    total_beats += row_len[r][ch];
                end
            end
            if (row_ord_n[r] > 0) ref_last = row_order[r][row_ord_n[r]-1];
        end
    endtask

    function automatic req_beat_t make_beat(input bit last);
        req_beat_t b;
        b.last = last;
        b.data = {$urandom, $urandom}; // random payload makes every beat unique.
        b.user = {$urandom, $urandom, $urandom, $urandom};
        b.keep = `RDMA_ARB_KEEP_W'($urandom);
        return b;
    endfunction

    // ****************************************
    // inputs change 1 ns after the rising edge.
    // ****************************************
    always @(posedge rdma_clk) begin
        #1;
        for (int ch = 0; ch < NCH; ch++) begin
            if (acc_flag[ch] && chq[ch].size() > 0) void'(chq[ch].pop_front()); // sent.
        end
        row_cyc++;
        for (int ch = 0; ch < NCH; ch++) begin
            s_req_valid[ch] = chq[ch].size() > 0 && (!cur_late[ch] || row_cyc >= LATE_CYC);
            s_req_beat[ch]  = s_req_valid[ch] ? chq[ch][0] : '0; // idle channels drive zero.
        end
        if (!driving) m_req_ready = 1'b1;
        else if (cur_rand) m_req_ready = ($urandom_range(3) != 0); // stall one cycle in four.
        else m_req_ready = cur_stall[row_cyc % 8];
    end

    // ****************************************
    // the monitor samples at the falling edge where every signal is settled.
    // ****************************************
    always @(negedge rdma_clk) begin
        acc_flag = s_req_valid & s_req_ready;
        if (rst_n && m_req_valid && m_req_ready) begin
            if (exp_q.size() == 0) begin
                assert (0) else begin
                    $display("an unexpected beat left the arbiter at %0t ns.", $time);
                    errs++;
                end
            end else begin
                exp_b = exp_q.pop_front();
                assert (m_req_beat == exp_b) else begin
                    $display("error @%0t: beat %h, expected %h.", $time, m_req_beat, exp_b);
                    errs++;
                end
            end
        end
    end

    // ****************************************
    // watchdog.
    // ****************************************
    initial begin
        wait (table_ready);
        repeat (total_beats * 4 + 200) @(posedge rdma_clk);
        $display("timeout: the arbiter did not drain the requests in time.");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ****************************************
    // test sequence.
    // ****************************************
    initial begin
        int n_fail;
        int row_errs;
        int ch;
        void'($urandom(32'h9456)); // one seed for the whole run.
        s_req_valid = '0;
        s_req_beat  = '0;
        m_req_ready = 1'b1;
        acc_flag    = '0;
        cur_late    = '0;
        cur_stall   = 8'hff;
        cur_rand    = 1'b0;
        driving     = 1'b0;
        row_cyc     = 0;
        errs        = 0;
        n_fail      = 0;
        set_row(0, 4'b1111, 4'b0000, 2, 3, 1, 2, 8'hff, 1'b0);      // all channels.
        set_row(1, 4'b0100, 4'b0000, 0, 0, 4, 0, 8'hff, 1'b0);      // one long packet.
        set_row(2, 4'b1111, 4'b0010, 2, 3, 1, 4, 8'hff, 1'b0);      // channel 1 joins late.
        set_row(3, 4'b1111, 4'b0000, 3, 2, 4, 1, 8'hff, 1'b1);      // random stalls.
        set_row(4, 4'b1010, 4'b0000, 0, 3, 0, 2, 8'b1101_1011, 1'b0);
        set_row(5, 4'b0001, 4'b0000, 1, 0, 0, 0, 8'hff, 1'b0);      // request after drain.
        build_orders();
        table_ready = 1'b1;

        // reset state and quiet output before any request.
        wait (rst_n);
        repeat (5) begin
            @(posedge rdma_clk);
            #2;
            assert (m_req_valid == 1'b0 && s_req_ready == '0 && m_req_beat == '0) else begin
                $display("error @%0t: output active with no request.", $time);
                errs++;
            end
        end
        $display("test 0: reset %s", (errs == 0) ? "ok" : "bad");
        if (errs != 0) n_fail++;

        for (int r = 0; r < N_ROWS; r++) begin
            row_errs = errs;
            @(posedge rdma_clk);
            #2;
            for (int i = 0; i < row_ord_n[r]; i++) begin
                ch = row_order[r][i];
                for (int b = 0; b < row_len[r][ch]; b++) begin
                    chq[ch].push_back(make_beat(b == row_len[r][ch] - 1));
                    exp_q.push_back(chq[ch][b]);
                end
            end
            cur_late  = row_late[r];
            cur_stall = row_stall[r];
            cur_rand  = row_rand[r];
            row_cyc   = 0;
            driving   = 1'b1;
            while (exp_q.size() != 0) @(posedge rdma_clk);
            driving = 1'b0;
            repeat (3) @(posedge rdma_clk);
            #2;
            assert (m_req_valid == 1'b0 && s_req_ready == '0) else begin
                $display("error @%0t: output still active after the queues drained.", $time);
                errs++;
            end
            if (errs != row_errs) n_fail++;
            $display("test %0d: row %0d with %0d packets %s", r + 1, r, row_ord_n[r],
                     (errs == row_errs) ? "ok" : "bad");
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 N_ROWS + 1, N_ROWS + 1 - n_fail, n_fail, errs, uut.u_checker.assert_fails);
        if (n_fail == 0 && uut.u_checker.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rdma_req_arbiter.f ====
+incdir+design
design/rdma_req_arb_pkg.sv
design/rr_grant_picker.sv
design/req_arb_fsm.sv
design/req_stream_mux.sv
design/rdma_req_arbiter.sv
sim/tb_clk_gen.sv
sim/rdma_req_arb_checker.sv
sim/tb_rdma_req_arbiter.sv

// ==== Makefile ====
# Verilator flow for the RDMA request arbiter.
VERILATOR ?= verilator
TOP       ?= tb_rdma_req_arbiter
FILELIST  ?= rdma_req_arbiter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
